// File: bench/mul_expand_tests.txt
# word hold check rd value flags, all hex
# hold 1 randomizes back-pressure, check 1 waits for idle and compares rd, value, NZCV
00200007 0 1 1 00000007 0
00400005 0 0 0 00000000 0
62624000 0 1 3 0000000C 0
64842000 0 1 4 FFFFFFFE 0
80A20003 0 1 5 00000015 0
80C40000 0 1 6 00000000 0
80E2FFFE 0 1 7 FFFFFFF2 0
75024000 0 1 8 00000002 2
81240004 0 1 9 00000014 2
9142FFFD 0 1 a FFFFFFEB 8
91620000 0 1 b 00000000 4
01800003 0 0 0 00000000 0
A1A58000 0 1 d 0000000F 4
65CC4000 0 0 0 00000000 0
B1E3C000 0 1 f FFFFFFDD 8
00200006 1 0 0 00000000 0
00400002 1 0 0 00000000 0
90620005 1 0 0 00000000 0
A0864000 1 1 4 0000003C 0
64AC4000 1 0 0 00000000 0
B0E6A000 1 1 7 FFFFFFC4 8
8108FFFF 1 1 8 FFFFFFC4 8
63308000 1 1 9 00000000 8

// File: bench/tb_mul_expand.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply expander
// Streams instruction words from the test file, keeps a register and flag
// model, checks every write-back in order and the state at checkpoints
////////////////////////////////////////////////////////////////////////////
module tb_mul_expand
    import ucode_pkg::*;
();

    localparam int in_timeout   = 200;  // Cycles to wait for in_ready
    localparam int idle_timeout = 1000; // Cycles to wait for busy to fall

    // One expected write-back
    typedef struct packed {
        logic [3:0]  rd;
        logic [31:0] value;
        logic [3:0]  flags; // N,Z,C,V
        logic        last;  // Final write-back of its instruction
    } exp_wb_t;

    logic      clk, rst, in_valid, in_ready, hold, wb_valid, busy;
    uop_word_u in_word;
    wb_t       wb;

    exp_wb_t     exp_q[$];     // Write-backs still to come, in order
    exp_wb_t     mon_exp;
    wb_t         last_wb;
    logic [31:0] ref_rf [16];  // Reference register file
    logic [3:0]  ref_flags;
    logic        hold_en;      // Record asks for random back-pressure
    integer      seed = 83783;

    mul_expand_top #(.fifo_depth(4)) dut_i (
        .clk, .rst, .in_valid, .in_ready, .in_word,
        .hold, .wb_valid, .wb, .busy
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    // Advance to the next falling edge and drive hold there
    task automatic step_cycle();
        integer rnd;
        @(negedge clk);
        rnd  = $random(seed);
        hold = hold_en && rnd[0];
    endtask

    // Reference semantics, queues one entry per expected write-back
    task automatic model_step(input uop_word_u w);
        logic [31:0] a, b, res, mult, mag;
        longint      sdiff;    // Exact signed difference
        logic        sflag;
        int          n_wb;
        exp_wb_t     e;
        a     = ref_rf[w.r.rn];
        b     = ref_rf[w.r.rm];
        res   = '0;
        mult  = (w.r.opcode == OP_MULR || w.r.opcode == OP_MULSR) ?
                b : {{16{w.i.imm[15]}}, w.i.imm};
        mag   = mult[31] ? -mult : mult;
        sflag = (w.r.opcode == OP_MULSI) || (w.r.opcode == OP_MULSR);
        n_wb  = 1;
        case (w.r.opcode)
            OP_MOVI: res = {16'd0, w.i.imm};
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_SUBS: begin
                res       = a - b;
                sdiff     = longint'($signed(a)) - longint'($signed(b));
                // V when the true difference leaves the signed 32-bit range
                ref_flags = {res[31], res == 32'd0, a >= b,
                             (sdiff > 64'sd2147483647) || (sdiff < -64'sd2147483648)};
            end
            OP_MULI, OP_MULR, OP_MULSI, OP_MULSR: begin
                res = a * mult; // Wraps modulo 2**32
                // Clear or move, the adds, two-step negate, then test
                n_wb = 1 + int'(sflag);
                if (mag != 32'd0) n_wb = n_wb + int'(mag) + (mult[31] ? 2 : 0);
                if (sflag) ref_flags = {res[31], res == 32'd0, 2'b00};
            end
            default: begin
                $display("Test file holds an opcode the model does not cover");
                stop_run();
            end
        endcase
        ref_rf[w.r.rd] = res;
        for (int i = 0; i < n_wb; i++) begin
            e.rd    = w.r.rd;
            e.value = res;
            e.flags = ref_flags;
            e.last  = (i == n_wb - 1);
            exp_q.push_back(e);
        end
    endtask

    // Called on a falling edge, returns on the edge after the transfer
    task automatic send_word(input uop_word_u w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_word  = w;
        #1;
        while (!in_ready) begin
            waited++;
            if (waited > in_timeout) begin
                $display("Timed out waiting for in_ready");
                stop_run();
            end
            step_cycle();
            #1;
        end
        step_cycle();
    endtask

    task automatic wait_idle();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        #1;
        while (busy) begin
            waited++;
            if (waited > idle_timeout) begin
                $display("Timed out waiting for busy to fall");
                stop_run();
            end
            step_cycle();
            #1;
        end
        step_cycle(); // Back on a falling edge
    endtask

    task automatic checkpoint(input logic [3:0] rd, input logic [31:0] value,
                              input logic [3:0] flags);
        wait_idle();
        if (exp_q.size() != 0) begin
            $display("Busy fell with %0d write-backs still missing", exp_q.size());
            stop_run();
        end
        check("wb.rd", last_wb.rd, rd);
        check("wb.value", last_wb.value, value);
        check("wb.flags", last_wb.flags, flags);
        check("ref_rf[rd]", ref_rf[rd], value); // Test file against the model
        check("ref_flags", ref_flags, flags);
    endtask

    // Write-back monitor, registered outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("Write-back to r%0d arrived with none expected", wb.rd);
                stop_run();
            end else begin
                mon_exp = exp_q.pop_front();
                check("wb.rd", wb.rd, mon_exp.rd); // Order of write-backs
                if (mon_exp.last) begin
                    check("wb.value", wb.value, mon_exp.value);
                    check("wb.flags", wb.flags, mon_exp.flags);
                end
                last_wb = wb;
            end
        end
    end

    initial begin
        integer      fd, fields;
        string       line;
        logic [31:0] word, hflag, chk, erd, evalue, eflags;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        hold     = 1'b0;
        hold_en  = 1'b0;
        last_wb  = '0;
        ref_flags = '0;
        for (int i = 0; i < 16; i++) ref_rf[i] = '0;
        repeat (16) step_cycle();
        rst = 1'b0;
        fd = $fopen("bench/mul_expand_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 8 || line[0] == "#") continue; // Comment or blank
            fields = $sscanf(line, "%h %h %h %h %h %h", word, hflag, chk, erd, evalue, eflags);
            if (fields != 6) begin
                $display("Malformed line in the test file");
                stop_run();
            end
            hold_en = hflag[0];
            model_step(word);
            send_word(word);
            if (chk[0]) checkpoint(erd[3:0], evalue, eflags[3:0]);
        end
        $fclose(fd);
        wait_idle();
        if (exp_q.size() != 0) begin
            $display("Run ended with %0d write-backs missing", exp_q.size());
            stop_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: common/ucode_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared encodings for the multiply microcode expander
// Opcodes, the two views of a micro-op word and the link structs
////////////////////////////////////////////////////////////////////////////
package ucode_pkg;

    // Executor opcodes plus the four multiply forms seen only on input
    typedef enum logic [6:0] {
        OP_MOVI  = 7'b0000000, // rd <= zero-extended imm
        OP_SUBI  = 7'b0010010, // rd <= rn - imm, flags kept
        OP_MOV   = 7'b0100000, // rd <= rn
        OP_TST   = 7'b0101000, // N,Z from rn, C,V cleared
        OP_ADD   = 7'b0110001,
        OP_SUB   = 7'b0110010,
        OP_NOT   = 7'b0110110,
        OP_ADDS  = 7'b0111001,
        OP_SUBS  = 7'b0111010,
        OP_MULI  = 7'b1000000, // rd <= rn * sext(imm)
        OP_MULSI = 7'b1001000,
        OP_MULR  = 7'b1010000, // rd <= rn * rm
        OP_MULSR = 7'b1011000,
        OP_NOP   = 7'b1100100
    } opcode_t;

    // Register form of a word
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rn;
        logic [3:0]  rm;
        logic [12:0] spare;
    } uop_r_t;

    // Immediate form, same opcode and rd/rn positions
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rn;
        logic        spare;
        logic [15:0] imm;
    } uop_i_t;

    typedef union packed {
        uop_r_t r;
        uop_i_t i;
    } uop_word_u;

    typedef enum logic [2:0] {
        K_PASS,
        K_MULI,
        K_MULR,
        K_MULSI,
        K_MULSR
    } mul_kind_t;

    // Decoder to sequencer request
    typedef struct packed {
        mul_kind_t   kind;
        logic [3:0]  rd;
        logic [3:0]  rn;
        logic [3:0]  rm;
        logic [15:0] imm;
        uop_word_u   word; // Original word, issued as is for pass-through
    } mul_req_t;

    typedef struct packed {
        uop_word_u word;
    } uop_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // One write-back report
    typedef struct packed {
        logic [3:0]  rd;
        logic [31:0] value;
        flags_t      flags;
    } wb_t;

endpackage

// File: src/mul_decode.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Classifies each word as pass-through or multiply form and holds the
// resulting request in a one-entry register for the sequencer
////////////////////////////////////////////////////////////////////////////
module mul_decode
    import ucode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  uop_word_u in_word,
    output logic      in_ready,
    output logic      req_valid,
    output mul_req_t  req,
    input  logic      req_ready
);

    mul_kind_t kind;

    // Multiply opcodes get their own kind, the rest pass through
    always_comb begin
        case (in_word.r.opcode)
            OP_MULI:  kind = K_MULI;
            OP_MULR:  kind = K_MULR;
            OP_MULSI: kind = K_MULSI;
            OP_MULSR: kind = K_MULSR;
            default:  kind = K_PASS;
        endcase
    end

    // Refill allowed in the same cycle the entry drains
    assign in_ready = !req_valid || req_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (in_ready) begin
            req_valid <= in_valid;
        end
    end

    // Request payload, both views of the same word
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req.kind <= kind;
            req.rd   <= in_word.r.rd;
            req.rn   <= in_word.r.rn;
            req.rm   <= in_word.r.rm; // Multiplier register for MULR forms
            req.imm  <= in_word.i.imm; // Multiplier for MULI forms
            req.word <= in_word;
        end
    end

endmodule

// File: src/mul_expand_top.sv
////////////////////////////////////////////////////////////////////////////
// Multiply expander top level
// Decoder, microcode sequencer, micro-op queue and executor in a chain
////////////////////////////////////////////////////////////////////////////
module mul_expand_top
    import ucode_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  uop_word_u in_word,
    input  logic      hold,
    output logic      wb_valid,
    output wb_t       wb,
    output logic      busy
);

    logic        req_valid, req_ready;
    mul_req_t    req;
    logic        uop_valid, uop_ready;
    uop_t        uop;
    logic        exec_valid, exec_ready;
    uop_t        exec_uop;
    logic        fifo_empty;
    logic [3:0]  rf_addr;
    logic [31:0] rf_data;

    mul_decode decode_i (
        .clk, .rst, .in_valid, .in_word, .in_ready,
        .req_valid, .req, .req_ready
    );

    ucode_seq seq_i (
        .clk, .rst, .req_valid, .req, .req_ready,
        .uop_valid, .uop, .uop_ready,
        .fifo_empty, .rf_addr, .rf_data
    );

    uop_fifo #(.fifo_depth(fifo_depth)) fifo_i (
        .clk, .rst,
        .in_valid(uop_valid), .in_uop(uop), .in_ready(uop_ready),
        .out_valid(exec_valid), .out_uop(exec_uop), .out_ready(exec_ready),
        .empty(fifo_empty)
    );

    uop_exec exec_i (
        .clk, .rst, .exec_valid, .exec_uop, .exec_ready, .hold,
        .rf_addr, .rf_data, .wb_valid, .wb
    );

    // Sequencer ready stays low through a multiply, also while the queue drains
    assign busy = req_valid | !req_ready | uop_valid | exec_valid | wb_valid;

endmodule

// File: src/uop_exec.sv
////////////////////////////////////////////////////////////////////////////
// Micro-op executor
// Sixteen 32-bit registers and NZCV flags, one micro-op per cycle,
// reports each write-back on the accepting edge
////////////////////////////////////////////////////////////////////////////
module uop_exec
    import ucode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        exec_valid,
    input  uop_t        exec_uop,
    output logic        exec_ready,
    input  logic        hold,
    input  logic [3:0]  rf_addr,
    output logic [31:0] rf_data,
    output logic        wb_valid,
    output wb_t         wb
);

    logic [31:0] regs [16];
    flags_t      flags, flags_nxt;
    opcode_t     op;
    logic [3:0]  rd, rn, rm;
    logic [31:0] a, b, imm, result;
    logic [32:0] sum, diff;  // Extra bit is the carry out
    logic        accept, wr_en, report;

    assign exec_ready = !hold; // Only back-pressure source
    assign accept     = exec_valid && exec_ready;
    assign rf_data    = regs[rf_addr]; // Sequencer operand read

    // Field positions are common to both views, imm only in the I view
    assign op  = exec_uop.word.r.opcode;
    assign rd  = exec_uop.word.r.rd;
    assign rn  = exec_uop.word.r.rn;
    assign rm  = exec_uop.word.r.rm;
    assign imm = {16'd0, exec_uop.word.i.imm};

    assign a    = regs[rn];
    assign b    = regs[rm];
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        result    = a;
        wr_en     = 1'b0;
        report    = 1'b1;
        flags_nxt = flags;
        case (op)
            OP_MOV:  wr_en = 1'b1;
            OP_MOVI: begin
                result = imm;
                wr_en  = 1'b1;
            end
            OP_ADD, OP_ADDS: begin
                result = sum[31:0];
                wr_en  = 1'b1;
                if (op == OP_ADDS) begin
                    flags_nxt.n = result[31];
                    flags_nxt.z = result == '0;
                    flags_nxt.c = sum[32];
                    flags_nxt.v = (a[31] == b[31]) && (result[31] != a[31]);
                end
            end
            OP_SUB, OP_SUBS: begin
                result = diff[31:0];
                wr_en  = 1'b1;
                if (op == OP_SUBS) begin
                    flags_nxt.n = result[31];
                    flags_nxt.z = result == '0;
                    flags_nxt.c = !diff[32]; // Set when no borrow
                    flags_nxt.v = (a[31] != b[31]) && (result[31] != a[31]);
                end
            end
            OP_SUBI: begin
                result = a - imm;
                wr_en  = 1'b1;
            end
            OP_NOT: begin
                result = ~a;
                wr_en  = 1'b1;
            end
            OP_TST: begin
                // Reports rn's value, no register write
                flags_nxt = '{n: a[31], z: a == '0, c: 1'b0, v: 1'b0};
            end
            default: report = 1'b0; // NOP and anything unknown
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) regs[i] <= '0;
            flags    <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= accept && report;
            if (accept) begin
                if (wr_en) regs[rd] <= result;
                flags <= flags_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb.rd    <= rd;
            wb.value <= result;
            wb.flags <= flags_nxt;
        end
    end

endmodule

// File: ucode/ucode_seq.sv
////////////////////////////////////////////////////////////////////////////
// Microcode sequencer
// Passes ordinary words through as one micro-op and expands multiplies
// into clear/move, repeated adds, negate fix-up and optional test
////////////////////////////////////////////////////////////////////////////
module ucode_seq
    import ucode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  mul_req_t    req,
    output logic        req_ready,
    output logic        uop_valid,
    output uop_t        uop,
    input  logic        uop_ready,
    input  logic        fifo_empty,
    output logic [3:0]  rf_addr,
    input  logic [31:0] rf_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_OPERAND, // Waits for the queue to drain before reading rm
        S_CLEAR,
        S_MOVE,
        S_ADD,
        S_FIX_SUB,
        S_FIX_NOT,
        S_TEST
    } state_t;

    state_t      state, state_nxt;
    mul_req_t    cur;     // Multiply being expanded
    logic [31:0] cnt;     // Adds still to issue
    logic        neg;     // Multiplier was negative
    logic        flag_set;
    logic        is_mul;
    logic        fire;
    logic [31:0] op_val;
    logic [31:0] op_mag;

    function automatic uop_t mk_r(opcode_t op, logic [3:0] rd, logic [3:0] rn,
                                  logic [3:0] rm);
        uop_t u;
        u = '0;
        u.word.r.opcode = op;
        u.word.r.rd     = rd;
        u.word.r.rn     = rn;
        u.word.r.rm     = rm;
        return u;
    endfunction

    function automatic uop_t mk_i(opcode_t op, logic [3:0] rd, logic [3:0] rn,
                                  logic [15:0] imm);
        uop_t u;
        u = '0;
        u.word.i.opcode = op;
        u.word.i.rd     = rd;
        u.word.i.rn     = rn;
        u.word.i.imm    = imm;
        return u;
    endfunction

    assign flag_set = (cur.kind == K_MULSI) || (cur.kind == K_MULSR);
    assign is_mul   = req.kind != K_PASS;
    assign fire     = uop_valid && uop_ready;
    assign rf_addr  = cur.rm;

    // Multiplier from rm in the read state, else sign-extended imm
    assign op_val = (state == S_READ_OPERAND) ? rf_data : {{16{req.imm[15]}}, req.imm};
    assign op_mag = op_val[31] ? -op_val : op_val;

    // Low for the whole expansion, its return marks the end of a multiply
    assign req_ready = (state == S_IDLE) && (!req_valid || is_mul || uop_ready);

    // rd is cleared before the adds, so rn must name another register
    always_comb begin
        state_nxt = state;
        uop_valid = 1'b0;
        uop       = mk_r(OP_NOP, cur.rd, cur.rd, cur.rd);
        case (state)
            S_IDLE: begin
                uop.word  = req.word; // Pass-through goes straight out
                uop_valid = req_valid && !is_mul;
                if (req_valid && is_mul) begin
                    if (req.kind == K_MULR || req.kind == K_MULSR) begin
                        state_nxt = S_READ_OPERAND;
                    end else begin
                        state_nxt = (op_mag == '0) ? S_CLEAR : S_MOVE;
                    end
                end
            end
            S_READ_OPERAND: begin
                if (fifo_empty) begin // All earlier writes have landed
                    state_nxt = (op_mag == '0) ? S_CLEAR : S_MOVE;
                end
            end
            S_CLEAR: begin
                uop       = mk_r(OP_SUB, cur.rd, cur.rd, cur.rd); // rd - rd = 0
                uop_valid = 1'b1;
                if (uop_ready) state_nxt = flag_set ? S_TEST : S_IDLE;
            end
            S_MOVE: begin
                uop       = mk_i(OP_MOVI, cur.rd, cur.rd, 16'd0);
                uop_valid = 1'b1;
                if (uop_ready) state_nxt = S_ADD;
            end
            S_ADD: begin
                uop       = mk_r(flag_set ? OP_ADDS : OP_ADD, cur.rd, cur.rd, cur.rn);
                uop_valid = 1'b1;
                if (uop_ready && cnt == 32'd1) begin
                    if (neg) state_nxt = S_FIX_SUB;
                    else     state_nxt = flag_set ? S_TEST : S_IDLE;
                end
            end
            S_FIX_SUB: begin
                // ~(x - 1) is -x
                uop       = mk_i(OP_SUBI, cur.rd, cur.rd, 16'd1);
                uop_valid = 1'b1;
                if (uop_ready) state_nxt = S_FIX_NOT;
            end
            S_FIX_NOT: begin
                uop       = mk_r(OP_NOT, cur.rd, cur.rd, 4'd0);
                uop_valid = 1'b1;
                if (uop_ready) state_nxt = flag_set ? S_TEST : S_IDLE;
            end
            S_TEST: begin
                uop       = mk_r(OP_TST, cur.rd, cur.rd, 4'd0); // Final N,Z, clear C,V
                uop_valid = 1'b1;
                if (uop_ready) state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            neg   <= 1'b0;
        end else begin
            state <= state_nxt;
            // Magnitude and sign latched when the count starts
            if ((state == S_IDLE || state == S_READ_OPERAND) &&
                (state_nxt == S_CLEAR || state_nxt == S_MOVE)) begin
                cnt <= op_mag;
                neg <= op_val[31];
            end else if (state == S_ADD && fire) begin
                cnt <= cnt - 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid && is_mul) cur <= req;
    end

endmodule

// File: ucode/uop_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Micro-op queue
// Circular buffer between sequencer and executor, push and pop allowed
// together even when full
////////////////////////////////////////////////////////////////////////////
module uop_fifo
    import ucode_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  uop_t in_uop,
    output logic in_ready,
    output logic out_valid,
    output uop_t out_uop,
    input  logic out_ready,
    output logic empty
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    uop_t             mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic [cnt_w-1:0] count;  // Occupancy
    logic             push, pop;

    assign empty     = count == '0;
    assign out_valid = !empty;
    assign out_uop   = mem[rd_ptr]; // Head entry straight from storage
    assign in_ready  = (count != cnt_w'(fifo_depth)) || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_uop;
    end

endmodule

// File: vlog.f
common/ucode_pkg.sv
src/mul_decode.sv
ucode/ucode_seq.sv
ucode/uop_fifo.sv
src/uop_exec.sv
src/mul_expand_top.sv
bench/tb_mul_expand.sv
